/* Bender.yml */
package:
  name: mips_core

sources:
  - hw/mipsPkg.sv
  - hw/hazardIf.sv
  - hw/pipeReg.sv
  - hw/fetchStage.sv
  - hw/decodeStage.sv
  - hw/executeStage.sv
  - hw/memoryStage.sv
  - hw/hazardUnit.sv
  - hw/mipsCore.sv
  - target: test
    files:
      - bench/mipsCore_assertions.sv
      - bench/mipsCoreTb.sv

/* bench/mipsCoreTb.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsCoreTb;
  import mipsPkg::*;

  localparam int numProgs     = 6;
  localparam int maxWords     = 16;
  localparam int maxStores    = 6;
  localparam int resetCycles  = 16;
  localparam int storeTimeout = 100;
  localparam int settleCycles = 20;

  logic     clk;
  logic     reset;
  logic     progWe;
  memIndexT progAddr;
  wordT     progData;
  logic     memWrite;
  wordT     memAddr;
  wordT     memWriteData;
  logic     lwStall;
  logic     branchTaken;
  logic     branchNotTaken;

  // one row per program with its words, ordered stores and status counts
  wordT progWords   [numProgs][maxWords];
  int   progLen     [numProgs];
  wordT expAddr     [numProgs][maxStores];
  wordT expData     [numProgs][maxStores];
  int   expStores   [numProgs];
  int   expTaken    [numProgs];
  int   expNotTaken [numProgs];
  int   expLwStall  [numProgs];
  int   curProg;

  wordT gotAddr [$];
  wordT gotData [$];
  int   takenCount;
  int   notTakenCount;
  int   lwStallCount;

  mipsCore u_mipsCore (
    .clk            (clk),
    .reset          (reset),
    .progWe         (progWe),
    .progAddr       (progAddr),
    .progData       (progData),
    .memWrite       (memWrite),
    .memAddr        (memAddr),
    .memWriteData   (memWriteData),
    .lwStall        (lwStall),
    .branchTaken    (branchTaken),
    .branchNotTaken (branchNotTaken)
  );

  bind mipsCore mipsCore_assertions u_assertions (
    .clk            (clk),
    .reset          (reset),
    .stallF         (hz.stallF),
    .stallD         (hz.stallD),
    .flushE         (hz.flushE),
    .memWrite       (memWrite),
    .branchTaken    (branchTaken),
    .branchNotTaken (branchNotTaken),
    .lwStall        (lwStall),
    .ctrlE          (idExE.ctrl)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // outputs are settled just before each rising edge
  always @(posedge clk)
  begin
    if (!reset)
    begin
      if (memWrite)
      begin
        gotAddr.push_back(memAddr);
        gotData.push_back(memWriteData);
      end
      if (branchTaken)
        takenCount++;
      if (branchNotTaken)
        notTakenCount++;
      if (lwStall)
        lwStallCount++;
    end
  end

  always @(posedge clk)
  begin
    if (u_mipsCore.u_assertions.failCount != 0)
      reportFailure("a bound assertion failed");
  end

  function automatic wordT encR(functT fn, regAddrT rd, regAddrT rs, regAddrT rt);
    return {opRtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic wordT encI(opcodeT op, regAddrT rt, regAddrT rs, int imm);
    return {op, rs, rt, 16'(imm)};
  endfunction

  // target is a word index
  function automatic wordT encJ(int target);
    return {opJ, 26'(target)};
  endfunction

  task automatic emit(input wordT w);
    progWords[curProg][progLen[curProg]] = w;
    progLen[curProg]++;
  endtask

  task automatic expectStore(input int addr, input int data);
    expAddr[curProg][expStores[curProg]] = wordT'(addr);
    expData[curProg][expStores[curProg]] = wordT'(data);
    expStores[curProg]++;
  endtask

  task automatic expectStatus(input int taken, input int notTaken, input int stalls);
    expTaken[curProg]    = taken;
    expNotTaken[curProg] = notTaken;
    expLwStall[curProg]  = stalls;
  endtask

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic checkWord(input string name, input wordT got, input wordT exp);
    if (got !== exp)
      reportFailure($sformatf("Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    if (got != exp)
      reportFailure($sformatf("Error: %s count = 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // every program ends in a jump to itself
  task automatic buildTable();
    // ALU ops and immediates with r1 = 12 and r2 = -5
    curProg = 0;
    emit(encI(opAddi, 1, 0, 12));
    emit(encI(opAddi, 2, 0, -5));
    emit(encR(fnAdd, 3, 1, 2));
    emit(encR(fnSub, 4, 1, 2));
    emit(encR(fnAnd, 5, 1, 2));
    emit(encR(fnOr, 6, 1, 2));
    emit(encR(fnSlt, 7, 2, 1));
    emit(encR(fnSlt, 8, 1, 2));
    emit(encI(opSw, 3, 0, 0));
    emit(encI(opSw, 4, 0, 4));
    emit(encI(opSw, 5, 0, 8));
    emit(encI(opSw, 6, 0, 12));
    emit(encI(opSw, 7, 0, 16));
    emit(encI(opSw, 8, 0, 20));
    emit(encJ(14));
    expectStore(0, 7);
    expectStore(4, 17);
    expectStore(8, 8);
    expectStore(12, 32'hffff_ffff);
    expectStore(16, 1);
    expectStore(20, 0);
    expectStatus(0, 0, 0);

    // chained results at distance 1 and 2
    curProg = 1;
    emit(encI(opAddi, 1, 0, 3));
    emit(encR(fnAdd, 2, 1, 1));
    emit(encR(fnAdd, 3, 2, 1));
    emit(encR(fnSub, 4, 3, 2));
    emit(encR(fnOr, 5, 4, 3));
    emit(encI(opSw, 5, 0, 0));
    emit(encR(fnAdd, 6, 5, 4));
    emit(encI(opSw, 6, 4, 5));
    emit(encI(opSw, 3, 0, 12));
    emit(encJ(9));
    expectStore(0, 11);
    expectStore(8, 14);
    expectStore(12, 9);
    expectStatus(0, 0, 0);

    // load-use with one stall per dependent load
    curProg = 2;
    emit(encI(opAddi, 1, 0, 21));
    emit(encI(opSw, 1, 0, 4));
    emit(encI(opLw, 2, 0, 4));
    emit(encR(fnAdd, 3, 2, 2));
    emit(encI(opSw, 3, 0, 8));
    emit(encI(opLw, 4, 0, 8));
    emit(encI(opSw, 4, 0, 12));
    emit(encJ(7));
    expectStore(4, 21);
    expectStore(8, 42);
    expectStore(12, 42);
    expectStatus(0, 0, 2);

    // taken and not-taken beq with some operands just computed
    curProg = 3;
    emit(encI(opAddi, 1, 0, 5));
    emit(encI(opAddi, 2, 0, 5));
    emit(encI(opBeq, 2, 1, 2));
    emit(encI(opSw, 1, 0, 0));
    emit(encI(opSw, 1, 0, 4));
    emit(encI(opAddi, 3, 0, 7));
    emit(encI(opBeq, 3, 1, 1));
    emit(encI(opSw, 3, 0, 8));
    emit(encR(fnSub, 4, 3, 1));
    emit(encI(opBeq, 0, 4, 1));
    emit(encI(opSw, 4, 0, 12));
    emit(encI(opBeq, 0, 0, 1));
    emit(encI(opSw, 1, 0, 16));
    emit(encI(opSw, 2, 0, 20));
    emit(encJ(14));
    expectStore(8, 7);
    expectStore(12, 2);
    expectStore(20, 5);
    expectStatus(2, 2, 0);

    // jump over two stores
    curProg = 4;
    emit(encI(opAddi, 1, 0, 9));
    emit(encJ(4));
    emit(encI(opSw, 1, 0, 0));
    emit(encI(opSw, 1, 0, 4));
    emit(encI(opSw, 1, 0, 8));
    emit(encI(opAddi, 2, 1, 1));
    emit(encI(opSw, 2, 0, 12));
    emit(encJ(7));
    expectStore(8, 9);
    expectStore(12, 10);
    expectStatus(0, 0, 0);

    // r3 and r4 hold old values until reset clears them
    curProg = 5;
    emit(encI(opSw, 3, 0, 0));
    emit(encI(opSw, 4, 0, 4));
    emit(encI(opAddi, 5, 4, 6));
    emit(encI(opSw, 5, 0, 8));
    emit(encJ(4));
    expectStore(0, 0);
    expectStore(4, 0);
    expectStore(8, 6);
    expectStatus(0, 0, 0);
  endtask

  task automatic runProgram(input int p);
    int waitCycles;
    // program words go in while reset is high
    for (int c = 0; c < resetCycles; c++)
    begin
      @(posedge clk);
      reset    <= 1'b1;
      progWe   <= (c < progLen[p]);
      progAddr <= memIndexT'(c);
      progData <= (c < progLen[p]) ? progWords[p][c] : '0;
      if (c == 1)
      begin
        gotAddr.delete();
        gotData.delete();
        takenCount    = 0;
        notTakenCount = 0;
        lwStallCount  = 0;
      end
    end
    @(posedge clk);
    reset  <= 1'b0;
    progWe <= 1'b0;
    for (int k = 0; k < expStores[p]; k++)
    begin
      waitCycles = 0;
      while (gotAddr.size() == 0)
      begin
        @(posedge clk);
        waitCycles++;
        if (waitCycles > storeTimeout)
          reportFailure($sformatf("no store %0d from program %0d within %0d cycles",
                                  k, p, storeTimeout));
      end
      checkWord("memAddr", gotAddr.pop_front(), expAddr[p][k]);
      checkWord("memWriteData", gotData.pop_front(), expData[p][k]);
    end
    repeat (settleCycles) @(posedge clk);
    if (gotAddr.size() != 0)
      reportFailure($sformatf("program %0d made an extra store to address 0x%08h",
                              p, gotAddr[0]));
    checkCount("branchTaken", takenCount, expTaken[p]);
    checkCount("branchNotTaken", notTakenCount, expNotTaken[p]);
    checkCount("lwStall", lwStallCount, expLwStall[p]);
  endtask

  initial
  begin
    reset    = 1'b1;
    progWe   = 1'b0;
    progAddr = '0;
    progData = '0;
    buildTable();
    for (int p = 0; p < numProgs; p++)
    begin
      runProgram(p);
    end
    if (u_mipsCore.u_assertions.failCount == 0)
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
    begin
      reportFailure("a bound assertion failed during the run");
    end
  end

endmodule

`default_nettype wire

/* bench/mipsCore_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsCore_assertions (
  input wire                clk,
  input wire                reset,
  input wire                stallF,
  input wire                stallD,
  input wire                flushE,
  input wire                memWrite,
  input wire                branchTaken,
  input wire                branchNotTaken,
  input wire                lwStall,
  input wire mipsPkg::ctrlT ctrlE
);
  import mipsPkg::*;

  // count of failed assertions
  int failCount = 0;

  // hazard unit raises all three from the same term
  stallsAgree: assert property (@(posedge clk) disable iff (reset)
    (stallF == stallD) && (stallD == flushE))
  else
  begin
    failCount++;
    $error("stallF, stallD and flushE differ");
  end

  // EX/MEM is cleared by the reset edge
  noStoreInReset: assert property (@(posedge clk) reset |=> !memWrite)
  else
  begin
    failCount++;
    $error("memWrite high while the core is in reset");
  end

  flagsExclusive: assert property (@(posedge clk) disable iff (reset)
    !(branchTaken && branchNotTaken))
  else
  begin
    failCount++;
    $error("branchTaken and branchNotTaken both high");
  end

  // a load writes a register from memory at base plus offset
  lwStallNeedsLoad: assert property (@(posedge clk) disable iff (reset)
    lwStall |-> (ctrlE.regWrite && ctrlE.memToReg && ctrlE.aluSrc &&
                 !ctrlE.memWrite && (ctrlE.aluOp == aluAdd)))
  else
  begin
    failCount++;
    $error("lwStall high without a load in execute");
  end

endmodule

`default_nettype wire

/* flist.f */
hw/mipsPkg.sv
hw/hazardIf.sv
hw/pipeReg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/hazardUnit.sv
hw/mipsCore.sv
bench/mipsCore_assertions.sv
bench/mipsCoreTb.sv

/* hw/decodeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
  input  wire                 clk,
  input  wire                 reset,
  input  wire mipsPkg::ifIdT  ifId,
  input  wire mipsPkg::memWbT memWb,
  input  wire mipsPkg::wordT  aluOutM,
  hazardIf.decode             hz,
  output mipsPkg::idExT       idEx,
  output mipsPkg::wordT       wbResult,
  output logic                branchTaken,
  output mipsPkg::wordT       branchTarget,
  output logic                jump,
  output logic [25:0]         jumpIndex,
  output logic                branchTakenFlag,
  output logic                branchNotTakenFlag
);
  import mipsPkg::*;

  opcodeT  opcode;
  functT   funct;
  regAddrT rs;
  regAddrT rt;
  regAddrT rd;
  wordT    signImm;
  ctrlT    ctrl;
  logic    branchD;
  logic    jumpD;
  wordT    regs [32];
  wordT    rdA;
  wordT    rdB;
  wordT    cmpA;
  wordT    cmpB;
  logic    equalD;

  assign opcode  = opcodeT'(ifId.instruction[31:26]);
  assign funct   = functT'(ifId.instruction[5:0]);
  assign rs      = ifId.instruction[25:21];
  assign rt      = ifId.instruction[20:16];
  assign rd      = ifId.instruction[15:11];
  assign signImm = {{16{ifId.instruction[15]}}, ifId.instruction[15:0]};

  always_comb
  begin
    ctrl    = '0;
    branchD = 1'b0;
    jumpD   = 1'b0;
    case (opcode)
      opRtype:
      begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = 1'b1;
        case (funct)
          fnAdd:   ctrl.aluOp = aluAdd;
          fnSub:   ctrl.aluOp = aluSub;
          fnAnd:   ctrl.aluOp = aluAnd;
          fnOr:    ctrl.aluOp = aluOr;
          fnSlt:   ctrl.aluOp = aluSlt;
          // unknown funct, including the all-zero nop
          default: ctrl = '0;
        endcase
      end
      opLw:
      begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opSw:
      begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opAddi:
      begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opBeq:   branchD = 1'b1;
      opJ:     jumpD = 1'b1;
      default: ctrl = '0;
    endcase
  end

  assign wbResult = memWb.memToReg ? memWb.readData : memWb.aluOut;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (memWb.regWrite && memWb.writeReg != '0)
    begin
      regs[memWb.writeReg] <= wbResult;
    end
  end

  // write-through so a same-cycle writeback is visible
  assign rdA = (rs == '0) ? '0 :
               (memWb.regWrite && memWb.writeReg == rs) ? wbResult : regs[rs];
  assign rdB = (rt == '0) ? '0 :
               (memWb.regWrite && memWb.writeReg == rt) ? wbResult : regs[rt];

  assign cmpA   = hz.forwardAD ? aluOutM : rdA;
  assign cmpB   = hz.forwardBD ? aluOutM : rdB;
  assign equalD = (cmpA == cmpB);

  assign branchTarget = ifId.pcPlus4 + {signImm[29:0], 2'b00};
  assign branchTaken  = branchD && equalD && !hz.stallD;
  assign jump         = jumpD && !hz.stallD;
  assign jumpIndex    = ifId.instruction[25:0];

  // flags only count a beq that actually leaves decode
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      branchTakenFlag    <= 1'b0;
      branchNotTakenFlag <= 1'b0;
    end
    else
    begin
      branchTakenFlag    <= branchD && !hz.stallD && equalD;
      branchNotTakenFlag <= branchD && !hz.stallD && !equalD;
    end
  end

  assign hz.rsD       = rs;
  assign hz.rtD       = rt;
  assign hz.branchD   = branchD;
  assign hz.writeRegW = memWb.writeReg;
  assign hz.regWriteW = memWb.regWrite;

  assign idEx.ctrl    = ctrl;
  assign idEx.srcA    = rdA;
  assign idEx.srcB    = rdB;
  assign idEx.rs      = rs;
  assign idEx.rt      = rt;
  assign idEx.rd      = rd;
  assign idEx.signImm = signImm;

endmodule

`default_nettype wire

/* hw/executeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module executeStage (
  input  wire mipsPkg::idExT idEx,
  input  wire mipsPkg::wordT aluOutM,
  input  wire mipsPkg::wordT wbResult,
  hazardIf.execute           hz,
  output mipsPkg::exMemT     exMem
);
  import mipsPkg::*;

  wordT aluA;
  wordT writeDataE;
  wordT aluB;
  wordT aluResult;

  // 10 picks memory, 01 picks writeback
  always_comb
  begin
    case (hz.forwardAE)
      2'b10:   aluA = aluOutM;
      2'b01:   aluA = wbResult;
      default: aluA = idEx.srcA;
    endcase
    case (hz.forwardBE)
      2'b10:   writeDataE = aluOutM;
      2'b01:   writeDataE = wbResult;
      default: writeDataE = idEx.srcB;
    endcase
  end

  assign aluB = idEx.ctrl.aluSrc ? idEx.signImm : writeDataE;

  always_comb
  begin
    case (idEx.ctrl.aluOp)
      aluAnd:  aluResult = aluA & aluB;
      aluOr:   aluResult = aluA | aluB;
      aluAdd:  aluResult = aluA + aluB;
      aluSub:  aluResult = aluA - aluB;
      aluSlt:  aluResult = {31'd0, $signed(aluA) < $signed(aluB)};
      default: aluResult = '0;
    endcase
  end

  assign exMem.regWrite  = idEx.ctrl.regWrite;
  assign exMem.memToReg  = idEx.ctrl.memToReg;
  assign exMem.memWrite  = idEx.ctrl.memWrite;
  assign exMem.aluOut    = aluResult;
  assign exMem.writeData = writeDataE;
  assign exMem.writeReg  = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

  assign hz.rsE       = idEx.rs;
  assign hz.rtE       = idEx.rt;
  assign hz.writeRegE = exMem.writeReg;
  assign hz.regWriteE = idEx.ctrl.regWrite;
  assign hz.memToRegE = idEx.ctrl.memToReg;

endmodule

`default_nettype wire

/* hw/fetchStage.sv */
`timescale 1ns/100ps
`default_nettype none

module fetchStage (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    progWe,
  input  wire mipsPkg::memIndexT progAddr,
  input  wire mipsPkg::wordT     progData,
  input  wire                    stall,
  input  wire                    branchTaken,
  input  wire mipsPkg::wordT     branchTarget,
  input  wire                    jump,
  input  wire [25:0]             jumpIndex,
  output mipsPkg::ifIdT          ifId
);
  import mipsPkg::*;

  wordT pc;
  wordT pcPlus4;
  wordT pcNext;
  wordT imem [imemDepth];

  // program is only loaded while the core is held in reset
  always_ff @(posedge clk)
  begin
    if (reset && progWe)
    begin
      imem[progAddr] <= progData;
    end
  end

  assign pcPlus4 = pc + 32'd4;

  // jump first, then a taken branch
  assign pcNext = jump        ? {pcPlus4[31:28], jumpIndex, 2'b00} :
                  branchTaken ? branchTarget :
                                pcPlus4;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc <= '0;
    end
    else if (!stall)
    begin
      pc <= pcNext;
    end
  end

  assign ifId.instruction = imem[pc[$clog2(imemDepth)+1:2]];
  assign ifId.pcPlus4     = pcPlus4;

endmodule

`default_nettype wire

/* hw/hazardIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface hazardIf;
  import mipsPkg::*;

  // decode side
  regAddrT    rsD;
  regAddrT    rtD;
  logic       branchD;
  logic       stallD;
  logic       forwardAD;
  logic       forwardBD;

  // execute side
  regAddrT    rsE;
  regAddrT    rtE;
  regAddrT    writeRegE;
  logic       regWriteE;
  logic       memToRegE;
  logic [1:0] forwardAE;
  logic [1:0] forwardBE;

  // memory and writeback
  regAddrT    writeRegM;
  logic       regWriteM;
  logic       memToRegM;
  regAddrT    writeRegW;
  logic       regWriteW;

  logic       stallF;
  logic       flushE;
  logic       lwStall;

  // decode owns the register file, so it also reports the writeback fields
  modport decode (
    output rsD, rtD, branchD, writeRegW, regWriteW,
    input  stallD, forwardAD, forwardBD
  );

  modport execute (
    output rsE, rtE, writeRegE, regWriteE, memToRegE,
    input  forwardAE, forwardBE
  );

  modport memory (
    output writeRegM, regWriteM, memToRegM
  );

  modport writeback (
    output writeRegW, regWriteW
  );

  modport hazard (
    input  rsD, rtD, branchD, rsE, rtE, writeRegE, regWriteE, memToRegE,
    input  writeRegM, regWriteM, memToRegM, writeRegW, regWriteW,
    output stallF, stallD, flushE, lwStall,
    output forwardAE, forwardBE, forwardAD, forwardBD
  );

endinterface

`default_nettype wire

/* hw/hazardUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
  hazardIf.hazard hz
);
  import mipsPkg::*;

  logic loadUseStall;
  logic branchStall;

  // memory has priority, register 0 is never forwarded
  function automatic logic [1:0] forwardSel(input regAddrT src);
    if (src != '0 && hz.regWriteM && src == hz.writeRegM)
      return 2'b10;
    else if (src != '0 && hz.regWriteW && src == hz.writeRegW)
      return 2'b01;
    else
      return 2'b00;
  endfunction

  always_comb
  begin
    hz.forwardAE = forwardSel(hz.rsE);
    hz.forwardBE = forwardSel(hz.rtE);
  end

  // decode compare only takes the ALU result from memory
  assign hz.forwardAD = (hz.rsD != '0) && hz.regWriteM && (hz.rsD == hz.writeRegM);
  assign hz.forwardBD = (hz.rtD != '0) && hz.regWriteM && (hz.rtD == hz.writeRegM);

  assign loadUseStall = hz.memToRegE &&
                        ((hz.writeRegE == hz.rsD) || (hz.writeRegE == hz.rtD));

  // beq operands not ready yet: ALU result still in execute, or a load in memory
  assign branchStall = hz.branchD &&
                       ((hz.regWriteE &&
                         ((hz.writeRegE == hz.rsD) || (hz.writeRegE == hz.rtD))) ||
                        (hz.memToRegM &&
                         ((hz.writeRegM == hz.rsD) || (hz.writeRegM == hz.rtD))));

  assign hz.stallF  = loadUseStall || branchStall;
  assign hz.stallD  = loadUseStall || branchStall;
  assign hz.flushE  = loadUseStall || branchStall;
  assign hz.lwStall = loadUseStall;

endmodule

`default_nettype wire

/* hw/memoryStage.sv */
`timescale 1ns/100ps
`default_nettype none

module memoryStage (
  input  wire                 clk,
  input  wire mipsPkg::exMemT exMem,
  hazardIf.memory             hz,
  output mipsPkg::memWbT      memWb,
  output logic                memWrite,
  output mipsPkg::wordT       memAddr,
  output mipsPkg::wordT       memWriteData
);
  import mipsPkg::*;

  wordT                         dmem [dmemDepth];
  logic [$clog2(dmemDepth)-1:0] dmemIndex;

  // word addressed, byte offset ignored
  assign dmemIndex = exMem.aluOut[$clog2(dmemDepth)+1:2];

  always_ff @(posedge clk)
  begin
    if (exMem.memWrite)
    begin
      dmem[dmemIndex] <= exMem.writeData;
    end
  end

  assign memWrite     = exMem.memWrite;
  assign memAddr      = exMem.aluOut;
  assign memWriteData = exMem.writeData;

  assign memWb.regWrite = exMem.regWrite;
  assign memWb.memToReg = exMem.memToReg;
  assign memWb.aluOut   = exMem.aluOut;
  assign memWb.readData = dmem[dmemIndex];
  assign memWb.writeReg = exMem.writeReg;

  assign hz.writeRegM = exMem.writeReg;
  assign hz.regWriteM = exMem.regWrite;
  assign hz.memToRegM = exMem.memToReg;

endmodule

`default_nettype wire

/* hw/mipsCore.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsCore (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    progWe,
  input  wire mipsPkg::memIndexT progAddr,
  input  wire mipsPkg::wordT     progData,
  output logic                   memWrite,
  output mipsPkg::wordT          memAddr,
  output mipsPkg::wordT          memWriteData,
  output logic                   lwStall,
  output logic                   branchTaken,
  output logic                   branchNotTaken
);
  import mipsPkg::*;

  ifIdT        ifIdF;
  ifIdT        ifIdD;
  idExT        idExD;
  idExT        idExE;
  exMemT       exMemE;
  exMemT       exMemM;
  memWbT       memWbM;
  memWbT       memWbW;
  wordT        wbResult;
  wordT        branchTarget;
  logic        redirectBranch;
  logic        jump;
  logic [25:0] jumpIndex;

  hazardIf hz ();

  fetchStage u_fetch (
    .clk          (clk),
    .reset        (reset),
    .progWe       (progWe),
    .progAddr     (progAddr),
    .progData     (progData),
    .stall        (hz.stallF),
    .branchTaken  (redirectBranch),
    .branchTarget (branchTarget),
    .jump         (jump),
    .jumpIndex    (jumpIndex),
    .ifId         (ifIdF)
  );

  // a taken branch or a jump squashes the instruction already fetched
  pipeReg #(.payloadT(ifIdT)) u_ifIdReg (
    .clk   (clk),
    .reset (reset),
    .hold  (hz.stallD),
    .clear (redirectBranch | jump),
    .d     (ifIdF),
    .q     (ifIdD)
  );

  decodeStage u_decode (
    .clk                (clk),
    .reset              (reset),
    .ifId               (ifIdD),
    .memWb              (memWbW),
    .aluOutM            (exMemM.aluOut),
    .hz                 (hz.decode),
    .idEx               (idExD),
    .wbResult           (wbResult),
    .branchTaken        (redirectBranch),
    .branchTarget       (branchTarget),
    .jump               (jump),
    .jumpIndex          (jumpIndex),
    .branchTakenFlag    (branchTaken),
    .branchNotTakenFlag (branchNotTaken)
  );

  pipeReg #(.payloadT(idExT)) u_idExReg (
    .clk   (clk),
    .reset (reset),
    .hold  (1'b0),
    .clear (hz.flushE),
    .d     (idExD),
    .q     (idExE)
  );

  executeStage u_execute (
    .idEx     (idExE),
    .aluOutM  (exMemM.aluOut),
    .wbResult (wbResult),
    .hz       (hz.execute),
    .exMem    (exMemE)
  );

  pipeReg #(.payloadT(exMemT)) u_exMemReg (
    .clk   (clk),
    .reset (reset),
    .hold  (1'b0),
    .clear (1'b0),
    .d     (exMemE),
    .q     (exMemM)
  );

  memoryStage u_memory (
    .clk          (clk),
    .exMem        (exMemM),
    .hz           (hz.memory),
    .memWb        (memWbM),
    .memWrite     (memWrite),
    .memAddr      (memAddr),
    .memWriteData (memWriteData)
  );

  pipeReg #(.payloadT(memWbT)) u_memWbReg (
    .clk   (clk),
    .reset (reset),
    .hold  (1'b0),
    .clear (1'b0),
    .d     (memWbM),
    .q     (memWbW)
  );

  hazardUnit u_hazard (
    .hz (hz.hazard)
  );

  assign lwStall = hz.lwStall;

endmodule

`default_nettype wire

/* hw/mipsPkg.sv */
`default_nettype none

package mipsPkg;

  localparam int dataWidth = 32;
  localparam int imemDepth = 64;
  localparam int dmemDepth = 64;

  typedef logic [dataWidth-1:0] wordT;
  typedef logic [4:0] regAddrT;
  typedef logic [$clog2(imemDepth)-1:0] memIndexT;

  // only the subset, anything else decodes as a no-op
  typedef enum logic [5:0] {
    opRtype = 6'h00,
    opJ     = 6'h02,
    opBeq   = 6'h04,
    opAddi  = 6'h08,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeT;

  typedef enum logic [5:0] {
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } functT;

  // bit 2 inverts the b operand for sub and slt
  typedef enum logic [2:0] {
    aluAnd = 3'b000,
    aluOr  = 3'b001,
    aluAdd = 3'b010,
    aluSub = 3'b110,
    aluSlt = 3'b111
  } aluOpT;

  // all zero is a bubble
  typedef struct packed {
    logic  regWrite;
    logic  memToReg;
    logic  memWrite;
    logic  aluSrc;
    logic  regDst;
    aluOpT aluOp;
  } ctrlT;

  typedef struct packed {
    wordT instruction;
    wordT pcPlus4;
  } ifIdT;

  typedef struct packed {
    ctrlT    ctrl;
    wordT    srcA;
    wordT    srcB;
    regAddrT rs;
    regAddrT rt;
    regAddrT rd;
    wordT    signImm;
  } idExT;

  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    logic    memWrite;
    wordT    aluOut;
    wordT    writeData;
    regAddrT writeReg;
  } exMemT;

  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    wordT    aluOut;
    wordT    readData;
    regAddrT writeReg;
  } memWbT;

endpackage

`default_nettype wire

/* hw/pipeReg.sv */
`timescale 1ns/100ps
`default_nettype none

module pipeReg #(
  parameter type payloadT = logic
) (
  input  wire          clk,
  input  wire          reset,
  input  wire          hold,
  input  wire          clear,
  input  wire payloadT d,
  output payloadT      q
);

  // clear wins over hold so a squash is never lost to a stall
  always_ff @(posedge clk)
  begin
    if (reset || clear)
    begin
      q <= '0;
    end
    else if (!hold)
    begin
      q <= d;
    end
  end

endmodule

`default_nettype wire
